/* src/sss_pkg.sv */
package sss_pkg;

    // one complex sample, imaginary part in the upper half
    localparam int SAMPLE_DW = 16;

    // sequence length and search range
    localparam int SSS_LEN    = 127;
    localparam int N_ID_1_MAX = 335;

    // identity field widths
    localparam int N_ID_1_W = 9;
    localparam int N_ID_W   = 10;
    localparam int N_ID_2_W = 2;

    // index into a 127 entry sequence, also wide enough to count to 127
    localparam int POS_W = $clog2(SSS_LEN);

    // m-sequence generators, x0 uses x^7 + x^4 + 1 and x1 uses x^7 + x + 1
    localparam int LFSR_N = 7;
    localparam logic [LFSR_N-1:0] LFSR_TAPS_0 = 7'h11;
    localparam logic [LFSR_N-1:0] LFSR_TAPS_1 = 7'h03;
    // x(0) = 1, x(1) to x(6) = 0
    localparam logic [LFSR_N-1:0] LFSR_START = 7'b0000001;

    // m1 runs through one group of 112 before m0 moves on
    localparam int SHIFT_GROUP = 112;

    // m0 = 15 * (N_id_1 / 112) + 5 * N_id_2
    localparam int M0_STEP_GROUP = 15;
    localparam int M0_STEP_NID2  = 5;

    // signed correlation sums, range -127 to +127
    localparam int ACC_W = 8;

endpackage

/* src/lfsr.sv */
`timescale 1ns/1ns

// Fibonacci LFSR, state bit 0 holds the oldest sequence value
module lfsr #(
    parameter int N = 7,
    parameter logic [N-1:0] TAPS = 'h11,
    parameter logic [N-1:0] START_VALUE = 'h01
) (
    input  logic clk_i,
    input  logic reset_ni,
    output logic data_o,
    output logic valid_o
);

    logic [N-1:0] state_q;
    logic         feedback;

    // next value of the sequence from the tapped positions
    assign feedback = ^(state_q & TAPS);

    assign data_o = state_q[0];

    // the start value is already the first output once reset is released
    assign valid_o = reset_ni;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= START_VALUE;
        end else begin
            // drop the oldest bit, append the new one on top
            state_q <= {feedback, state_q[N-1:1]};
        end
    end

endmodule

/* src/m_seq_gen.sv */
`timescale 1ns/1ns

module m_seq_gen import sss_pkg::*; (
    input  logic               clk_i,
    input  logic               reset_ni,
    output logic [SSS_LEN-1:0] m_seq_0_o,
    output logic [SSS_LEN-1:0] m_seq_1_o,
    output logic               seq_ready_o
);

    logic             bit_0;
    logic             bit_1;
    logic             valid_0;
    logic             valid_1;
    logic             store;
    logic [POS_W-1:0] wr_cnt_q;

    lfsr #(
        .N          (LFSR_N),
        .TAPS       (LFSR_TAPS_0),
        .START_VALUE(LFSR_START)
    ) i_lfsr_0 (
        .clk_i   (clk_i),
        .reset_ni(reset_ni),
        .data_o  (bit_0),
        .valid_o (valid_0)
    );

    lfsr #(
        .N          (LFSR_N),
        .TAPS       (LFSR_TAPS_1),
        .START_VALUE(LFSR_START)
    ) i_lfsr_1 (
        .clk_i   (clk_i),
        .reset_ni(reset_ni),
        .data_o  (bit_1),
        .valid_o (valid_1)
    );

    // one full period is captured, then the registers are frozen
    assign store = valid_0 && valid_1 && !seq_ready_o;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_cnt_q    <= '0;
            seq_ready_o <= 1'b0;
        end else if (store) begin
            if (wr_cnt_q == POS_W'(SSS_LEN - 1)) begin
                seq_ready_o <= 1'b1;
            end else begin
                wr_cnt_q <= wr_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (store) begin
            m_seq_0_o[wr_cnt_q] <= bit_0;
            m_seq_1_o[wr_cnt_q] <= bit_1;
        end
    end

endmodule

/* src/sss_capture.sv */
`timescale 1ns/1ns

module sss_capture import sss_pkg::*; (
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  logic [SAMPLE_DW-1:0] sample_i,
    input  logic                 sample_valid_i,
    input  logic                 release_i,
    output logic [SSS_LEN-1:0]   chips_i_o,
    output logic [SSS_LEN-1:0]   chips_q_o,
    output logic                 full_o
);

    logic [POS_W-1:0] wr_cnt_q;
    logic             accept;
    logic             chip_i;
    logic             chip_q;

    // input is ignored while a block waits for the search
    assign accept = sample_valid_i && !full_o;

    // hard BPSK decision, a positive value gives chip 1
    assign chip_i = ~sample_i[SAMPLE_DW/2-1];
    assign chip_q = ~sample_i[SAMPLE_DW-1];

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_cnt_q <= '0;
            full_o   <= 1'b0;
        end else begin
            if (accept) begin
                if (wr_cnt_q == POS_W'(SSS_LEN - 1)) begin
                    // last chip of the block, next block starts at 0 again
                    wr_cnt_q <= '0;
                    full_o   <= 1'b1;
                end else begin
                    wr_cnt_q <= wr_cnt_q + 1'b1;
                end
            end
            if (release_i) begin
                full_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            chips_i_o[wr_cnt_q] <= chip_i;
            chips_q_o[wr_cnt_q] <= chip_q;
        end
    end

endmodule

/* src/sss_correlator.sv */
`timescale 1ns/1ns

module sss_correlator import sss_pkg::*; (
    input  logic                clk_i,
    input  logic                reset_ni,
    input  logic [N_ID_2_W-1:0] n_id_2_i,
    input  logic                n_id_2_valid_i,
    input  logic [SSS_LEN-1:0]  m_seq_0_i,
    input  logic [SSS_LEN-1:0]  m_seq_1_i,
    input  logic                seq_ready_i,
    input  logic [SSS_LEN-1:0]  chips_i_i,
    input  logic [SSS_LEN-1:0]  chips_q_i,
    input  logic                buf_full_i,
    output logic                buf_release_o,
    output logic [N_ID_1_W-1:0] n_id_1_o,
    output logic [N_ID_W-1:0]   n_id_o,
    output logic                n_id_valid_o
);

    logic [N_ID_2_W-1:0]     n_id_2_q;
    logic                    n_id_2_set_q;
    logic                    busy_q;
    logic [POS_W-1:0]        cnt_q;
    logic [N_ID_1_W-1:0]     n_id_1_q;
    logic signed [ACC_W-1:0] acc_i_q;
    logic signed [ACC_W-1:0] acc_q_q;
    // datapath registers, loaded at the start of a search
    logic [N_ID_2_W-1:0]     run_n_id_2_q;
    logic [POS_W-1:0]        m0_q;
    logic [POS_W-1:0]        m1_q;
    logic [POS_W-1:0]        pos0_q;
    logic [POS_W-1:0]        pos1_q;
    logic [ACC_W-1:0]        best_q;
    logic [N_ID_1_W-1:0]     best_n_id_1_q;

    logic                    start;
    logic                    accum;
    logic                    decide;
    logic                    last_cand;
    logic                    group_end;
    logic [POS_W-1:0]        base0;
    logic [POS_W-1:0]        idx0;
    logic [POS_W-1:0]        idx1;
    logic                    ref_chip;
    logic [ACC_W-1:0]        abs_i;
    logic [ACC_W-1:0]        abs_q;
    logic [ACC_W-1:0]        peak;
    logic                    win;
    logic [N_ID_1_W-1:0]     win_n_id_1;

    function automatic logic [POS_W-1:0] wrap_inc(input logic [POS_W-1:0] p);
        return (p == POS_W'(SSS_LEN - 1)) ? '0 : p + 1'b1;
    endfunction

    // m0 offset of candidate 0, 5 * N_id_2
    always_comb begin
        case (n_id_2_q)
            2'd0:    base0 = '0;
            2'd1:    base0 = POS_W'(M0_STEP_NID2);
            2'd2:    base0 = POS_W'(2 * M0_STEP_NID2);
            default: base0 = POS_W'(3 * M0_STEP_NID2);
        endcase
    end

    // the start cycle already correlates chip 0 of candidate 0
    assign start  = !busy_q && !buf_release_o && buf_full_i && seq_ready_i && n_id_2_set_q;
    assign decide = busy_q && (cnt_q == POS_W'(SSS_LEN));
    assign accum  = (start || busy_q) && !decide;

    assign idx0 = busy_q ? pos0_q : base0;
    assign idx1 = busy_q ? pos1_q : '0;

    // d(n) = (1 - 2 x0) (1 - 2 x1), as a chip: 1 when both bits agree
    assign ref_chip = ~(m_seq_0_i[idx0] ^ m_seq_1_i[idx1]);

    assign abs_i      = acc_i_q[ACC_W-1] ? -acc_i_q : acc_i_q;
    assign abs_q      = acc_q_q[ACC_W-1] ? -acc_q_q : acc_q_q;
    assign peak       = (abs_i > abs_q) ? abs_i : abs_q;
    // strict compare keeps the lowest N_id_1 on a tie
    assign win        = peak > best_q;
    assign win_n_id_1 = win ? n_id_1_q : best_n_id_1_q;
    assign last_cand  = n_id_1_q == N_ID_1_W'(N_ID_1_MAX);
    assign group_end  = m1_q == POS_W'(SHIFT_GROUP - 1);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            n_id_2_q     <= '0;
            n_id_2_set_q <= 1'b0;
        end else if (n_id_2_valid_i) begin
            n_id_2_q     <= n_id_2_i;
            n_id_2_set_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            busy_q        <= 1'b0;
            cnt_q         <= '0;
            n_id_1_q      <= '0;
            acc_i_q       <= '0;
            acc_q_q       <= '0;
            buf_release_o <= 1'b0;
            n_id_valid_o  <= 1'b0;
            n_id_1_o      <= '0;
            n_id_o        <= '0;
        end else begin
            buf_release_o <= 1'b0;
            n_id_valid_o  <= 1'b0;
            if (start) begin
                busy_q   <= 1'b1;
                n_id_1_q <= '0;
            end
            if (accum) begin
                acc_i_q <= (chips_i_i[cnt_q] == ref_chip) ? acc_i_q + 1'b1 : acc_i_q - 1'b1;
                acc_q_q <= (chips_q_i[cnt_q] == ref_chip) ? acc_q_q + 1'b1 : acc_q_q - 1'b1;
                cnt_q   <= cnt_q + 1'b1;
            end
            if (decide) begin
                cnt_q   <= '0;
                acc_i_q <= '0;
                acc_q_q <= '0;
                if (last_cand) begin
                    busy_q        <= 1'b0;
                    buf_release_o <= 1'b1;
                    n_id_valid_o  <= 1'b1;
                    n_id_1_o      <= win_n_id_1;
                    // 3 * N_id_1 + N_id_2
                    n_id_o <= N_ID_W'(win_n_id_1) + N_ID_W'(win_n_id_1)
                            + N_ID_W'(win_n_id_1) + N_ID_W'(run_n_id_2_q);
                end else begin
                    n_id_1_q <= n_id_1_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            run_n_id_2_q <= n_id_2_q;
            m0_q         <= base0;
            m1_q         <= '0;
            best_q       <= '0;
        end
        if (accum) begin
            pos0_q <= wrap_inc(idx0);
            pos1_q <= wrap_inc(idx1);
        end
        if (decide) begin
            if (win) begin
                best_q        <= peak;
                best_n_id_1_q <= n_id_1_q;
            end
            // shifts of the next candidate, m0 moves by 15 per group of 112
            if (group_end) begin
                m0_q   <= m0_q + POS_W'(M0_STEP_GROUP);
                m1_q   <= '0;
                pos0_q <= m0_q + POS_W'(M0_STEP_GROUP);
                pos1_q <= '0;
            end else begin
                m1_q   <= m1_q + 1'b1;
                pos0_q <= m0_q;
                pos1_q <= m1_q + 1'b1;
            end
        end
    end

endmodule

/* src/sss_detector_top.sv */
`timescale 1ns/1ns

module sss_detector_top import sss_pkg::*; (
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  logic [SAMPLE_DW-1:0] sample_i,
    input  logic                 sample_valid_i,
    input  logic [N_ID_2_W-1:0]  n_id_2_i,
    input  logic                 n_id_2_valid_i,
    output logic [N_ID_1_W-1:0]  n_id_1_o,
    output logic [N_ID_W-1:0]    n_id_o,
    output logic                 n_id_valid_o
);

    logic [SSS_LEN-1:0] m_seq_0;
    logic [SSS_LEN-1:0] m_seq_1;
    logic               seq_ready;
    logic [SSS_LEN-1:0] chips_i;
    logic [SSS_LEN-1:0] chips_q;
    logic               buf_full;
    logic               buf_release;

    m_seq_gen i_m_seq_gen (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .m_seq_0_o  (m_seq_0),
        .m_seq_1_o  (m_seq_1),
        .seq_ready_o(seq_ready)
    );

    sss_capture i_sss_capture (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .sample_i      (sample_i),
        .sample_valid_i(sample_valid_i),
        .release_i     (buf_release),
        .chips_i_o     (chips_i),
        .chips_q_o     (chips_q),
        .full_o        (buf_full)
    );

    sss_correlator i_sss_correlator (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .n_id_2_i      (n_id_2_i),
        .n_id_2_valid_i(n_id_2_valid_i),
        .m_seq_0_i     (m_seq_0),
        .m_seq_1_i     (m_seq_1),
        .seq_ready_i   (seq_ready),
        .chips_i_i     (chips_i),
        .chips_q_i     (chips_q),
        .buf_full_i    (buf_full),
        .buf_release_o (buf_release),
        .n_id_1_o      (n_id_1_o),
        .n_id_o        (n_id_o),
        .n_id_valid_o  (n_id_valid_o)
    );

endmodule

/* bench/sss_tb_ref.svh */
`ifndef SSS_TB_REF_SVH
`define SSS_TB_REF_SVH

// each half of a sample is a signed byte, so the amplitude must stay below 128
localparam int HALF_DW = SAMPLE_DW / 2;
localparam int REF_AMP = 100;

// x0(i+7) = x0(i+4) + x0(i) mod 2, with x0(0) = 1 and x0(1..6) = 0
function automatic bit [SSS_LEN-1:0] ref_x0();
    bit [SSS_LEN-1:0] x;
    int               i;
    x    = '0;
    x[0] = 1'b1;
    for (i = 0; i < SSS_LEN - 7; i++) begin
        x[i+7] = x[i+4] ^ x[i];
    end
    return x;
endfunction

// x1(i+7) = x1(i+1) + x1(i) mod 2, same start
function automatic bit [SSS_LEN-1:0] ref_x1();
    bit [SSS_LEN-1:0] x;
    int               i;
    x    = '0;
    x[0] = 1'b1;
    for (i = 0; i < SSS_LEN - 7; i++) begin
        x[i+7] = x[i+1] ^ x[i];
    end
    return x;
endfunction

function automatic int ref_m0(input int n_id_1, input int n_id_2);
    return 15 * (n_id_1 / 112) + 5 * n_id_2;
endfunction

function automatic int ref_m1(input int n_id_1);
    return n_id_1 % 112;
endfunction

// chip n of the SSS, 1 stands for +1
function automatic bit ref_chip(input int n_id_1, input int n_id_2, input int n);
    bit [SSS_LEN-1:0] x0;
    bit [SSS_LEN-1:0] x1;
    bit               b0;
    bit               b1;
    x0 = ref_x0();
    x1 = ref_x1();
    b0 = x0[(n + ref_m0(n_id_1, n_id_2)) % SSS_LEN];
    b1 = x1[(n + ref_m1(n_id_1)) % SSS_LEN];
    // (1 - 2 b0)(1 - 2 b1) is +1 when the bits agree
    return ~(b0 ^ b1);
endfunction

// +-REF_AMP on the chosen half, zero on the other
function automatic logic [SAMPLE_DW-1:0] ref_sample(input bit chip, input bit on_imag);
    logic [HALF_DW-1:0] part;
    part = chip ? HALF_DW'(REF_AMP) : HALF_DW'(-REF_AMP);
    return on_imag ? {part, {HALF_DW{1'b0}}} : {{HALF_DW{1'b0}}, part};
endfunction

`endif

/* bench/tb_sss_detector.sv */
`timescale 1ns/1ns

module tb_sss_detector import sss_pkg::*; #(
    parameter int SEED = 39
) ();

    localparam int TIMEOUT_CYCLES = 50000;
    // longer than one full search, so a search started without N_id_2 would show
    localparam int HOLD_CYCLES    = (N_ID_1_MAX + 1) * (SSS_LEN + 1) + 100;

    logic                 clk_i;
    logic                 reset_ni;
    logic [SAMPLE_DW-1:0] sample_i;
    logic                 sample_valid_i;
    logic [N_ID_2_W-1:0]  n_id_2_i;
    logic                 n_id_2_valid_i;
    logic [N_ID_1_W-1:0]  n_id_1_o;
    logic [N_ID_W-1:0]    n_id_o;
    logic                 n_id_valid_o;

    integer seed;
    bit     result_expected;
    bit     any_result;
    int     nid1;
    int     nid2;
    int     prev_id;

    `include "sss_tb_ref.svh"

    sss_detector_top i_sss_detector_top (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .sample_i      (sample_i),
        .sample_valid_i(sample_valid_i),
        .n_id_2_i      (n_id_2_i),
        .n_id_2_valid_i(n_id_2_valid_i),
        .n_id_1_o      (n_id_1_o),
        .n_id_o        (n_id_o),
        .n_id_valid_o  (n_id_valid_o)
    );

    always #50 clk_i = ~clk_i;

    task automatic report_mismatch(input string what);
        $display("MISMATCH at %0t ns: %s", $time, what);
        $display("TEST FAILED");
        $fatal(1, "value check failed");
    endtask

    // a result may only appear once a full frame and N_id_2 are in place
    no_spurious_result: assert property (@(posedge clk_i) disable iff (!reset_ni)
        n_id_valid_o |-> result_expected)
        else report_mismatch("n_id_valid_o expected 0, got 1");

    single_cycle_pulse: assert property (@(posedge clk_i) disable iff (!reset_ni)
        n_id_valid_o |=> !n_id_valid_o)
        else report_mismatch("n_id_valid_o longer than one cycle");

    zero_before_result: assert property (@(posedge clk_i) disable iff (!reset_ni)
        (!any_result && !n_id_valid_o) |-> (n_id_o == '0 && n_id_1_o == '0))
        else report_mismatch($sformatf("outputs expected 0, got n_id %0d", n_id_o));

    task automatic pick_identity();
        nid1 = $unsigned($random(seed)) % (N_ID_1_MAX + 1);
        nid2 = $unsigned($random(seed)) % 3;
    endtask

    task automatic send_n_id_2(input int n_id_2);
        @(posedge clk_i);
        #1;
        n_id_2_i       = N_ID_2_W'(n_id_2);
        n_id_2_valid_i = 1'b1;
        @(posedge clk_i);
        #1;
        n_id_2_valid_i = 1'b0;
    endtask

    task automatic send_frame(input int n_id_1, input int n_id_2, input bit on_imag,
                              input bit invert, input int flips);
        bit [SSS_LEN-1:0] flip_mask;
        int               pos;
        int               n;
        bit               chip;
        flip_mask = '0;
        while ($countones(flip_mask) < flips) begin
            pos            = $unsigned($random(seed)) % SSS_LEN;
            flip_mask[pos] = 1'b1;
        end
        for (n = 0; n < SSS_LEN; n++) begin
            chip = ref_chip(n_id_1, n_id_2, n) ^ invert ^ flip_mask[n];
            @(posedge clk_i);
            #1;
            sample_i       = ref_sample(chip, on_imag);
            sample_valid_i = 1'b1;
        end
        @(posedge clk_i);
        #1;
        sample_valid_i = 1'b0;
        sample_i       = '0;
    endtask

    task automatic check_result(input int n_id_1, input int n_id_2);
        int cycles;
        cycles          = 0;
        result_expected = 1'b1;
        @(posedge clk_i);
        #1;
        while (!n_id_valid_o && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            #1;
            cycles++;
        end
        if (!n_id_valid_o) begin
            $display("timeout, no result from the detector after %0d cycles", cycles);
            $display("TEST FAILED");
            $fatal(1, "detector gave no result");
        end
        assert (n_id_1_o == N_ID_1_W'(n_id_1))
            else report_mismatch($sformatf("n_id_1_o expected %0d, got %0d", n_id_1, n_id_1_o));
        assert (n_id_o == N_ID_W'(3 * n_id_1 + n_id_2))
            else report_mismatch($sformatf("n_id_o expected %0d, got %0d",
                                           3 * n_id_1 + n_id_2, n_id_o));
        // the pulse is still sampled by the properties at the next edge
        @(posedge clk_i);
        #1;
        result_expected = 1'b0;
        any_result      = 1'b1;
    endtask

    initial begin
        seed            = SEED;
        clk_i           = 1'b0;
        reset_ni        = 1'b0;
        sample_i        = '0;
        sample_valid_i  = 1'b0;
        n_id_2_i        = '0;
        n_id_2_valid_i  = 1'b0;
        result_expected = 1'b0;
        any_result      = 1'b0;
        repeat (3) @(posedge clk_i);
        #1;
        reset_ni = 1'b1;

        // frame waits in the buffer until N_id_2 is known
        pick_identity();
        send_frame(nid1, nid2, 1'b0, 1'b0, 0);
        repeat (HOLD_CYCLES) @(posedge clk_i);
        send_n_id_2(nid2);
        check_result(nid1, nid2);

        // clean SSS on the real part
        pick_identity();
        send_n_id_2(nid2);
        send_frame(nid1, nid2, 1'b0, 1'b0, 0);
        check_result(nid1, nid2);

        // inverted SSS on the imaginary part only
        pick_identity();
        send_n_id_2(nid2);
        send_frame(nid1, nid2, 1'b1, 1'b1, 0);
        check_result(nid1, nid2);

        // ten chip errors, then a frame that arrives during the search
        pick_identity();
        send_n_id_2(nid2);
        send_frame(nid1, nid2, 1'b0, 1'b0, 10);
        prev_id = 3 * nid1 + nid2;
        repeat (10) @(posedge clk_i);
        send_frame((nid1 + 57) % (N_ID_1_MAX + 1), nid2, 1'b0, 1'b0, 0);
        check_result(nid1, nid2);

        // frame after the release carries its own identity
        pick_identity();
        while (3 * nid1 + nid2 == prev_id) begin
            pick_identity();
        end
        send_n_id_2(nid2);
        send_frame(nid1, nid2, 1'b0, 1'b0, 0);
        check_result(nid1, nid2);

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* sources.f */
+incdir+bench
src/sss_pkg.sv
src/lfsr.sv
src/m_seq_gen.sv
src/sss_capture.sv
src/sss_correlator.sv
src/sss_detector_top.sv
bench/tb_sss_detector.sv

/* Makefile */
VERILATOR       ?= verilator
TOP             ?= tb_sss_detector
SEED            ?= 39
BUILD_DIR       ?= obj_dir
VERILATOR_FLAGS ?= --timing --assert -Wno-fatal
LINT_FLAGS      ?= --timing -Wall

FILELIST := sources.f

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VERILATOR_FLAGS) -GSEED=$(SEED) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
